//--- n64_vdi.f
+incdir+include
hw/n64_vdi_pkg.sv
hw/n64_vdemux.sv
hw/n64_vinfo_ext.sv
hw/n64_vstat_cnt.sv
hw/n64_vdi_axil_regs.sv
hw/n64_vdi_top.sv
tests/n64_vdi_checker.sv
tests/tb_n64_vdi.sv

//--- Bender.yml
package:
  name: n64_vdi

sources:
  - include_dirs:
      - include
    files:
      - hw/n64_vdi_pkg.sv
      - hw/n64_vdemux.sv
      - hw/n64_vinfo_ext.sv
      - hw/n64_vstat_cnt.sv
      - hw/n64_vdi_axil_regs.sv
      - hw/n64_vdi_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/n64_vdi_checker.sv
      - tests/tb_n64_vdi.sv

//--- tests/tb_n64_vdi.sv
// testbench of the video input front end
//   clock, reset, LFSR driven four phase video stream with model
//   AXI4-Lite host tasks with stalled responses
//   watchdog and closing report

`default_nettype none

`include "n64_vdi_params.svh"

module tb_n64_vdi;

  localparam int PIX        = 8;   // pixels per line, kept short
  localparam int NUM_FRAMES = 6;
  localparam int WD_LIMIT   = NUM_FRAMES * `N64_LINES_PAL * PIX * 4 * 8 + 20000;

  logic nCLK, rst_n, nDSYNC;
  logic [`N64_DW-1:0] d, r, g, b;
  logic [3:0] sync_out;
  logic pixel_valid;
  logic [`N64_AXI_AW-1:0] awaddr, araddr;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [`N64_AXI_DW-1:0] wdata, rdata;
  logic [3:0] wstrb;
  logic [1:0] bresp, rresp;

  // ======================================================================
  // model state, updated at each phase 0 as the stream is driven
  // ======================================================================
  logic [15:0] lfsr = 16'd58605;
  logic [3:0]  mdl_nib   = 4'hF;
  logic        mdl_i480  = 1'b1;
  logic        mdl_vmode = 1'b0;
  logic        mdl_id    = 1'b0;    // odd frame id of the last frame
  logic        last_pal  = 1'b0;    // last complete frame had PAL length
  int          mdl_run = 0, mdl_lines = 0, mdl_frames = 0;
  int          stat_frame = 0;      // frame whose registers may be read

  n64_vdi_top u_dut (
    .nCLK, .rst_n, .nDSYNC, .d, .r, .g, .b, .sync_out, .pixel_valid,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
  );

  n64_vdi_checker u_chk (
    .nCLK, .pixel_valid, .r, .g, .b, .sync_out,
    .blurry_pixel_pos(u_dut.u_vinfo_ext.blurry_pixel_pos)
  );

  initial begin
    nCLK = 1'b0;
    forever #4 nCLK = ~nCLK;
  end

  initial begin
    #(WD_LIMIT);
    $display("watchdog expired, the run did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v    = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  // ======================================================================
  // video stream with model
  // ======================================================================
  task run_stream;
    logic [15:0] v;
    logic pal, aligned, vs, hs, cs, vr, vf, hr, hf, crs, exp_blur;
    logic blur_due, blur_exp;         // a CSYNC rise is seen one pixel later
    logic [3:0] nib;
    logic [6:0] cr, cg, cb;
    int nlines;
    blur_due = 1'b0;
    blur_exp = 1'b0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      v = take_bits(1);
      pal = v[0];
      v = take_bits(1);
      aligned = v[0];                 // VSYNC fall lands on an HSYNC fall
      nlines = pal ? `N64_LINES_PAL : `N64_LINES_NTSC;
      for (int l = 0; l < nlines; l++) begin
        for (int p = 0; p < PIX; p++) begin
          hs = (p >= 2);
          vs = !(l < 3 || (l == 3 && p < 4));
          if (!aligned && l == 0 && p < 4)
            vs = 1'b1;                // late fall, mid line
          cs  = hs & vs;
          nib = {vs, 1'b1, hs, cs};
          vr  = !mdl_nib[3] && nib[3];
          vf  =  mdl_nib[3] && !nib[3];
          hr  = !mdl_nib[1] && nib[1];
          hf  =  mdl_nib[1] && !nib[1];
          crs = !mdl_nib[0] && nib[0];
          exp_blur = mdl_i480 ? 1'b1 : mdl_vmode;   // values before this edge is seen
          if (vf) begin
            mdl_i480 = (hf != mdl_id);
            mdl_id   = hf;
          end
          if (vr) begin
            mdl_lines = mdl_run + 1;
            mdl_run   = 0;
            mdl_vmode = last_pal;     // PAL length reads as 1
            mdl_frames++;
          end else if (hr) begin
            mdl_run++;
          end
          mdl_nib = nib;
          v = take_bits(7);
          cr = v[6:0];
          v = take_bits(7);
          cg = v[6:0];
          v = take_bits(7);
          cb = v[6:0];
          u_chk.push_pixel({nib, cr, cg, cb});
          if (l == 6 && p == 0 && f > 0)
            stat_frame = f;
          nDSYNC = 1'b0;              // phase 0, sync nibble
          d      = {3'b000, nib};
          @(posedge nCLK);
          #1;
          if (blur_due)               // rise of the last pixel, reloaded on this edge
            u_chk.check_blurry(blur_exp);
          blur_due = crs && (l >= 4) && (f > 0);
          blur_exp = exp_blur;
          nDSYNC = 1'b1;
          d      = cr;
          @(posedge nCLK);
          #1 d = cg;
          @(posedge nCLK);
          #1 d = cb;
          @(posedge nCLK);
          #1;
        end
      end
      last_pal = pal;
    end
    nDSYNC = 1'b0;                    // idle phase 0, no further pixel
    d      = {3'b000, mdl_nib};
  endtask

  // ======================================================================
  // AXI4-Lite host
  // ======================================================================
  task axi_write(input logic [4:0] addr, input logic [31:0] data, output logic [1:0] resp);
    logic [15:0] v;
    int n;
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    do begin
      @(posedge nCLK);
      n++;
    end while (!(awready && wready) && n < 200);
    if (n >= 200) begin
      u_chk.note_failure($sformatf("AXI write to %0h never completed", addr));
      resp = 2'bxx;
    end else begin
      @(posedge nCLK);                // transfer on the falling edge between
      v = take_bits(3);               // stall span for bready
      #1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      resp = bresp;
      repeat (v[2:0]) begin
        @(posedge nCLK);
        if (!bvalid || bresp !== resp)
          u_chk.note_failure("write response dropped or changed while stalled");
      end
      #1 bready = 1'b1;
      @(posedge nCLK);
      #1 bready = 1'b0;
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task axi_read(input logic [4:0] addr, output logic [31:0] data, output logic [1:0] resp);
    logic [15:0] v;
    int n;
    araddr = addr;
    arvalid = 1'b1;
    n = 0;
    do begin
      @(posedge nCLK);
      n++;
    end while (!arready && n < 200);
    if (n >= 200) begin
      u_chk.note_failure($sformatf("AXI read from %0h never completed", addr));
      data = 'x;
      resp = 2'bxx;
    end else begin
      @(posedge nCLK);
      v = take_bits(3);               // stall span for rready
      #1 arvalid = 1'b0;
      data = rdata;
      resp = rresp;
      repeat (v[2:0]) begin
        @(posedge nCLK);
        if (!rvalid || rdata !== data || rresp !== resp)
          u_chk.note_failure("read response dropped or changed while stalled");
      end
      #1 rready = 1'b1;
      @(posedge nCLK);
      #1 rready = 1'b0;
    end
    arvalid = 1'b0;
  endtask

  task run_host;
    logic [31:0] rd;
    logic [1:0]  rs;
    for (int f = 1; f < NUM_FRAMES; f++) begin
      wait (stat_frame == f);
      @(posedge nCLK);
      #1;
      axi_read(`N64_REG_STATUS, rd, rs);
      u_chk.check_value("STATUS {480i, vmode}", rd[2:1], {mdl_i480, mdl_vmode});
      axi_read(`N64_REG_LINES, rd, rs);
      u_chk.check_value("LINES", rd, mdl_lines);
      axi_read(`N64_REG_FRAMES, rd, rs);
      u_chk.check_value("FRAMES", rd, mdl_frames);
      if (f == 2) begin               // unmapped offsets
        axi_write(5'h14, 32'h1, rs);
        u_chk.check_value("BRESP unmapped", rs, 2'b10);
        axi_read(5'h1C, rd, rs);
        u_chk.check_value("RRESP unmapped", rs, 2'b10);
      end
      if (f == 3) begin               // clear the frame counter
        axi_write(`N64_REG_CTRL, 32'h1, rs);
        u_chk.check_value("BRESP CTRL", rs, 2'b00);
        mdl_frames = 0;
        axi_read(`N64_REG_FRAMES, rd, rs);
        u_chk.check_value("FRAMES after clear", rd, 0);
      end
    end
  endtask

  // ======================================================================
  // main sequence
  // ======================================================================
  initial begin
    int total;
    rst_n   = 1'b0;
    nDSYNC  = 1'b1;
    d       = '0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (16) @(posedge nCLK);
    #1 rst_n = 1'b1;                  // first phase 0 goes out right away
    fork
      run_stream;
      run_host;
    join
    repeat (8) @(posedge nCLK);
    u_chk.final_check;
    total = u_chk.pix_errors + u_chk.reg_errors + u_chk.other_errors;
    $display("errors: pixel %0d, register %0d, other %0d",
             u_chk.pix_errors, u_chk.reg_errors, u_chk.other_errors);
    if (total == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/n64_vdi_checker.sv
// testbench checker for the video input front end
//   expected pixel queue and pixel_valid comparison
//   value checks for register reads and the blurry pixel position
//   error counters for the closing report

`default_nettype none

`include "n64_vdi_params.svh"

module n64_vdi_checker (
  input  wire logic              nCLK,
  input  wire logic              pixel_valid,
  input  wire logic [`N64_DW-1:0] r,
  input  wire logic [`N64_DW-1:0] g,
  input  wire logic [`N64_DW-1:0] b,
  input  wire logic [3:0]        sync_out,
  input  wire logic              blurry_pixel_pos
);

  logic [3*`N64_DW+3:0] exp_q[$];   // {sync, r, g, b} in stream order
  int pix_errors   = 0;
  int reg_errors   = 0;
  int other_errors = 0;

  task push_pixel(input logic [3*`N64_DW+3:0] px);
    exp_q.push_back(px);
  endtask

  // outputs change on the falling edge, sampled on the rising one
  always @(posedge nCLK) begin
    if (pixel_valid) begin
      if (exp_q.size() == 0) begin
        $display("FAILED %0t: pixel out with no pixel expected", $time);
        pix_errors++;
      end else if ({sync_out, r, g, b} !== exp_q[0]) begin
        $display("FAILED %0t: pixel got %h expected %h", $time,
                 {sync_out, r, g, b}, exp_q[0]);
        pix_errors++;
        void'(exp_q.pop_front());
      end else begin
        void'(exp_q.pop_front());
      end
    end
  end

  task check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %0t: %s got %0h expected %0h", $time, what, got, exp);
      reg_errors++;
    end
  endtask

  task check_blurry(input logic exp);
    check_value("blurry_pixel_pos after CSYNC rise", {31'd0, blurry_pixel_pos}, {31'd0, exp});
  endtask

  task note_failure(input string msg);
    $display("%0t: %s", $time, msg);   // plain words, not a value mismatch
    other_errors++;
  endtask

  // pixels still queued were never produced
  task final_check;
    if (exp_q.size() != 0)
      note_failure($sformatf("%0d expected pixels never came out", exp_q.size()));
  endtask

endmodule

`default_nettype wire

//--- hw/n64_vdi_top.sv
// top level of the video input front end
// demux, video info, statistics and host register slave

`default_nettype none

`include "n64_vdi_params.svh"

module n64_vdi_top (
  input  wire logic                       nCLK,
  input  wire logic                       rst_n,
  input  wire logic                       nDSYNC,
  input  wire logic [`N64_DW-1:0]         d,
  // pixel out
  output logic [`N64_DW-1:0]              r,
  output logic [`N64_DW-1:0]              g,
  output logic [`N64_DW-1:0]              b,
  output logic [3:0]                      sync_out,
  output logic                            pixel_valid,
  // host AXI4-Lite
  input  wire logic [`N64_AXI_AW-1:0]     awaddr,
  input  wire logic                       awvalid,
  output logic                            awready,
  input  wire logic [`N64_AXI_DW-1:0]     wdata,
  input  wire logic [`N64_AXI_DW/8-1:0]   wstrb,
  input  wire logic                       wvalid,
  output logic                            wready,
  output logic [1:0]                      bresp,
  output logic                            bvalid,
  input  wire logic                       bready,
  input  wire logic [`N64_AXI_AW-1:0]     araddr,
  input  wire logic                       arvalid,
  output logic                            arready,
  output logic [`N64_AXI_DW-1:0]          rdata,
  output logic [1:0]                      rresp,
  output logic                            rvalid,
  input  wire logic                       rready
);

  logic [3:0]               sync_pre;
  logic [3:0]               sync_cur;
  logic [1:0]               data_cnt;
  logic                     n64_480i;
  logic                     vmode;
  logic                     blurry_pixel_pos;
  logic [`N64_LINE_CW-1:0]  line_count;
  logic [`N64_FRAME_CW-1:0] frame_count;
  logic                     clear;

  n64_vdemux u_vdemux (
    .nCLK, .rst_n, .nDSYNC, .d, .data_cnt,
    .sync_pre, .sync_cur, .r, .g, .b, .sync_out, .pixel_valid
  );

  n64_vinfo_ext u_vinfo_ext (
    .nCLK, .rst_n, .nDSYNC, .sync_pre, .sync_cur,
    .data_cnt, .n64_480i, .vmode, .blurry_pixel_pos
  );

  n64_vstat_cnt u_vstat_cnt (
    .nCLK, .rst_n, .nDSYNC, .sync_pre, .sync_cur, .clear,
    .line_count, .frame_count
  );

  n64_vdi_axil_regs u_regs (
    .nCLK, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .data_cnt, .n64_480i, .vmode, .blurry_pixel_pos,
    .line_count, .frame_count, .r, .g, .b, .sync_out,
    .clear
  );

endmodule

`default_nettype wire

//--- hw/n64_vdi_axil_regs.sv
// AXI4-Lite register slave of the video input front end
//   write channel pair accepted together, one response at a time
//   read channel with a registered response
//   status, line count, frame count, pixel and control registers

`default_nettype none

`include "n64_vdi_params.svh"

module n64_vdi_axil_regs (
  input  wire logic                       nCLK,
  input  wire logic                       rst_n,
  // write address / data / response
  input  wire logic [`N64_AXI_AW-1:0]     awaddr,
  input  wire logic                       awvalid,
  output logic                            awready,
  input  wire logic [`N64_AXI_DW-1:0]     wdata,
  input  wire logic [`N64_AXI_DW/8-1:0]   wstrb,
  input  wire logic                       wvalid,
  output logic                            wready,
  output n64_vdi_pkg::axi_resp_e          bresp,
  output logic                            bvalid,
  input  wire logic                       bready,
  // read address / data
  input  wire logic [`N64_AXI_AW-1:0]     araddr,
  input  wire logic                       arvalid,
  output logic                            arready,
  output logic [`N64_AXI_DW-1:0]          rdata,
  output n64_vdi_pkg::axi_resp_e          rresp,
  output logic                            rvalid,
  input  wire logic                       rready,
  // status sources
  input  wire logic [1:0]                 data_cnt,
  input  wire logic                       n64_480i,
  input  wire logic                       vmode,
  input  wire logic                       blurry_pixel_pos,
  input  wire logic [`N64_LINE_CW-1:0]    line_count,
  input  wire logic [`N64_FRAME_CW-1:0]   frame_count,
  input  wire logic [`N64_DW-1:0]         r,
  input  wire logic [`N64_DW-1:0]         g,
  input  wire logic [`N64_DW-1:0]         b,
  input  wire logic [3:0]                 sync_out,
  output logic                            clear
);

  import n64_vdi_pkg::*;

  reg_idx_e               wr_idx;
  reg_idx_e               rd_idx;
  logic                   wr_fire;
  logic                   rd_fire;
  logic [`N64_AXI_DW-1:0] rd_word;

  // byte offset to register word, unaligned offsets fall to REG_NONE
  function automatic reg_idx_e decode(input logic [`N64_AXI_AW-1:0] addr);
    case (addr)
      `N64_REG_STATUS: decode = REG_STATUS;
      `N64_REG_LINES:  decode = REG_LINES;
      `N64_REG_FRAMES: decode = REG_FRAMES;
      `N64_REG_PIXEL:  decode = REG_PIXEL;
      `N64_REG_CTRL:   decode = REG_CTRL;
      default:         decode = REG_NONE;
    endcase
  endfunction

  assign wr_idx  = decode(awaddr);
  assign rd_idx  = decode(araddr);
  assign wr_fire = awvalid && awready && wvalid && wready;
  assign rd_fire = arvalid && arready;

  // ======================================================================
  // write channel
  // ======================================================================
  always_ff @(negedge nCLK or negedge rst_n) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      clear   <= 1'b0;
    end else begin
      // ready for one cycle once AW and W are both there and B is free
      awready <= awvalid && wvalid && !awready && !bvalid;
      wready  <= awvalid && wvalid && !awready && !bvalid;
      clear   <= wr_fire && (wr_idx == REG_CTRL) && wstrb[0] && wdata[0];
      if (wr_fire)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;               // held until the host takes it
    end
  end

  always_ff @(negedge nCLK) begin
    if (wr_fire)
      bresp <= (wr_idx == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
  end

  // ======================================================================
  // read channel
  // ======================================================================
  always_comb begin
    rd_word = '0;
    case (rd_idx)
      REG_STATUS: rd_word[4:0] = {data_cnt, n64_480i, vmode, blurry_pixel_pos};
      REG_LINES:  rd_word[`N64_LINE_CW-1:0]  = line_count;
      REG_FRAMES: rd_word[`N64_FRAME_CW-1:0] = frame_count;
      REG_PIXEL:  rd_word[3*`N64_DW+3:0]     = {sync_out, r, g, b};
      default:    ;                   // CTRL reads back 0
    endcase
  end

  always_ff @(negedge nCLK or negedge rst_n) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid && !arready && !rvalid;  // no new read while R stalls
      if (rd_fire)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  // data and response stay stable while rvalid waits for rready
  always_ff @(negedge nCLK) begin
    if (rd_fire) begin
      rdata <= rd_word;
      rresp <= (rd_idx == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

//--- hw/n64_vstat_cnt.sv
// video statistics
// lines per frame, latched at each nVSYNC rising edge
// running frame count with a host clear

`default_nettype none

`include "n64_vdi_params.svh"

module n64_vstat_cnt (
  input  wire logic                     nCLK,
  input  wire logic                     rst_n,
  input  wire logic                     nDSYNC,
  input  wire logic [3:0]               sync_pre,
  input  wire logic [3:0]               sync_cur,
  input  wire logic                     clear,        // one cycle pulse from the host
  output logic [`N64_LINE_CW-1:0]       line_count,
  output logic [`N64_FRAME_CW-1:0]      frame_count
);

  import n64_vdi_pkg::*;

  logic                    vsync_rise;
  logic                    hsync_rise;
  logic [`N64_LINE_CW-1:0] line_run;   // lines seen in the current frame

  // sync edges are only valid in the phase 0 cycle
  assign vsync_rise = !nDSYNC && !sync_pre[SYNC_VSYNC] && sync_cur[SYNC_VSYNC];
  assign hsync_rise = !nDSYNC && !sync_pre[SYNC_HSYNC] && sync_cur[SYNC_HSYNC];

  // ======================================================================
  // line counter
  // ======================================================================
  always_ff @(negedge nCLK or negedge rst_n) begin
    if (!rst_n) begin
      line_run   <= '0;
      line_count <= '0;
    end else if (vsync_rise) begin
      line_count <= line_run + 1'b1;   // the VSYNC line itself counts too
      line_run   <= '0;
    end else if (hsync_rise && (line_run != '1)) begin
      line_run   <= line_run + 1'b1;   // saturate on a broken stream
    end
  end

  // ======================================================================
  // frame counter
  // ======================================================================
  always_ff @(negedge nCLK or negedge rst_n) begin
    if (!rst_n)
      frame_count <= '0;
    else if (clear)
      frame_count <= '0;               // host clear wins over a VSYNC rise
    else if (vsync_rise)
      frame_count <= frame_count + 1'b1;
  end

endmodule

`default_nettype wire

//--- hw/n64_vinfo_ext.sv
// video info extraction from the sync nibble
//   data phase counter for the demux
//   240p/480i detection from the odd/even frame ID
//   PAL/NTSC mode and blurry pixel position

`default_nettype none

module n64_vinfo_ext (
  input  wire logic       nCLK,
  input  wire logic       rst_n,
  input  wire logic       nDSYNC,
  input  wire logic [3:0] sync_pre,
  input  wire logic [3:0] sync_cur,
  output logic [1:0]      data_cnt,
  output logic            n64_480i,         // 1 = 480i/576i
  output logic            vmode,            // 1 = PAL
  output logic            blurry_pixel_pos
);

  import n64_vdi_pkg::*;

  logic       vsync_rise;
  logic       vsync_fall;
  logic       hsync_rise;
  logic       hsync_fall;
  logic       csync_rise;
  logic       frame_id;   // 1 = odd frame
  logic [1:0] line_cnt;   // only bit 1 matters, PAL leaves it at 0

  // edges between the two most recent sync nibbles
  assign vsync_rise = !sync_pre[SYNC_VSYNC] &&  sync_cur[SYNC_VSYNC];
  assign vsync_fall =  sync_pre[SYNC_VSYNC] && !sync_cur[SYNC_VSYNC];
  assign hsync_rise = !sync_pre[SYNC_HSYNC] &&  sync_cur[SYNC_HSYNC];
  assign hsync_fall =  sync_pre[SYNC_HSYNC] && !sync_cur[SYNC_HSYNC];
  assign csync_rise = !sync_pre[SYNC_CSYNC] &&  sync_cur[SYNC_CSYNC];

  // ======================================================================
  // data phase counter
  // ======================================================================
  always_ff @(negedge nCLK or negedge rst_n) begin
    if (!rst_n)
      data_cnt <= 2'd0;
    else if (!nDSYNC)
      data_cnt <= 2'd1;             // next cycle is red
    else
      data_cnt <= data_cnt + 2'd1;  // green, blue, then wraps to 0
  end

  // ======================================================================
  // 240p / 480i
  // ======================================================================
  always_ff @(negedge nCLK or negedge rst_n) begin
    if (!rst_n) begin
      frame_id <= 1'b0;
      n64_480i <= 1'b1;
    end else if (!nDSYNC && vsync_fall) begin
      if (hsync_fall) begin         // VSYNC and HSYNC fall together
        n64_480i <= ~frame_id;      // interlaced if the last one was even
        frame_id <= 1'b1;
      end else begin
        n64_480i <= frame_id;
        frame_id <= 1'b0;
      end
    end
  end

  // ======================================================================
  // vmode and blurry pixel position
  // ======================================================================
  always_ff @(negedge nCLK or negedge rst_n) begin
    if (!rst_n) begin
      line_cnt         <= 2'd0;
      vmode            <= 1'b0;
      blurry_pixel_pos <= 1'b1;
    end else if (!nDSYNC) begin
      if (vsync_rise) begin
        line_cnt <= 2'd0;
        vmode    <= ~line_cnt[1];   // PAL when bit 1 is still clear
      end else if (hsync_rise) begin
        line_cnt <= line_cnt + 2'd1;
      end
      if (n64_480i)
        blurry_pixel_pos <= 1'b1;   // fixed in interlaced modes
      else if (csync_rise)
        blurry_pixel_pos <= vmode;  // realign at line start
      else
        blurry_pixel_pos <= ~blurry_pixel_pos;
    end
  end

endmodule

`default_nettype wire

//--- hw/n64_vdemux.sv
// video bus demultiplexer
// sync nibble capture into the pre/cur pair for edge detection
// colour sample steering by the data phase count
// whole pixel output with a one cycle valid pulse

`default_nettype none

`include "n64_vdi_params.svh"

module n64_vdemux (
  input  wire logic               nCLK,
  input  wire logic               rst_n,
  input  wire logic               nDSYNC,
  input  wire logic [`N64_DW-1:0] d,
  input  wire logic [1:0]         data_cnt,     // 1 red, 2 green, 3 blue
  output logic [3:0]              sync_pre,
  output logic [3:0]              sync_cur,
  output logic [`N64_DW-1:0]      r,
  output logic [`N64_DW-1:0]      g,
  output logic [`N64_DW-1:0]      b,
  output logic [3:0]              sync_out,
  output logic                    pixel_valid
);

  logic [`N64_DW-1:0] r_hold;   // red waits here for green and blue
  logic [`N64_DW-1:0] g_hold;
  logic               blue_phase;

  // blue is the last colour phase, the pixel is complete on that edge
  assign blue_phase = nDSYNC && (data_cnt == 2'd3);

  // ======================================================================
  // sync nibble pair
  // ======================================================================
  // idle level of every sync line is high, so reset to all ones
  // and no edge shows up right after reset
  always_ff @(negedge nCLK or negedge rst_n) begin
    if (!rst_n) begin
      sync_pre <= 4'hF;
      sync_cur <= 4'hF;
    end else if (!nDSYNC) begin   // phase 0 carries the sync nibble
      sync_cur <= d[3:0];
      sync_pre <= sync_cur;       // previous pixel
    end
  end

  // ======================================================================
  // colour steering
  // ======================================================================
  always_ff @(negedge nCLK) begin
    if (nDSYNC) begin
      case (data_cnt)
        2'd1:    r_hold <= d;
        2'd2:    g_hold <= d;
        default: ;                // blue goes straight to the output
      endcase
    end
  end

  // output registers, loaded together so r/g/b/sync never mix pixels
  always_ff @(negedge nCLK) begin
    if (blue_phase) begin
      r        <= r_hold;
      g        <= g_hold;
      b        <= d;
      sync_out <= sync_cur;       // nibble of this very pixel
    end
  end

  always_ff @(negedge nCLK or negedge rst_n) begin
    if (!rst_n)
      pixel_valid <= 1'b0;
    else
      pixel_valid <= blue_phase;  // high for exactly one cycle
  end

endmodule

`default_nettype wire

//--- hw/n64_vdi_pkg.sv
// shared types of the video input front end
//   sync_bit_e  position of each signal in the sync nibble
//   reg_idx_e   register word decoded from a host address
//   axi_resp_e  AXI response codes used by the slave

`default_nettype none

package n64_vdi_pkg;

  // sync nibble is {nVSYNC, nCLAMP, nHSYNC, nCSYNC}, all active low
  typedef enum logic [1:0] {
    SYNC_CSYNC = 2'd0,
    SYNC_HSYNC = 2'd1,
    SYNC_CLAMP = 2'd2,
    SYNC_VSYNC = 2'd3
  } sync_bit_e;

  // register words, REG_NONE for anything unmapped
  typedef enum logic [2:0] {
    REG_STATUS = 3'd0,
    REG_LINES  = 3'd1,
    REG_FRAMES = 3'd2,
    REG_PIXEL  = 3'd3,
    REG_CTRL   = 3'd4,
    REG_NONE   = 3'd7
  } reg_idx_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10   // unmapped offset
  } axi_resp_e;

endpackage

`default_nettype wire

//--- include/n64_vdi_params.svh
// shared width macros for the video input front end
// register byte offsets of the host AXI4-Lite slave
// nominal line counts per frame for NTSC and PAL

`ifndef N64_VDI_PARAMS_SVH
`define N64_VDI_PARAMS_SVH

// ======================================================================
// widths
// ======================================================================
`define N64_DW        7   // one colour sample, also the input bus
`define N64_LINE_CW  10   // line counter, up to 1024 lines
`define N64_FRAME_CW 16   // frame counter
`define N64_AXI_AW    5   // host address width
`define N64_AXI_DW   32   // host data width

// ======================================================================
// register byte offsets
// ======================================================================
`define N64_REG_STATUS 5'h00   // {data_cnt, n64_480i, vmode, blurry_pixel_pos}
`define N64_REG_LINES  5'h04   // lines of the last complete frame
`define N64_REG_FRAMES 5'h08   // frames since reset or clear
`define N64_REG_PIXEL  5'h0C   // {sync_out, r, g, b}
`define N64_REG_CTRL   5'h10   // bit 0 clears the frame counter

// frame line thresholds
`define N64_LINES_NTSC 263
`define N64_LINES_PAL  313

`endif
